/* hdl/decode_defs.svh */
// widths shared by the decode stage and its testbench
// RV64I only: XLEN and PC_W are fixed at 64, instructions are 32 bits
// REG_NUM and REG_ADDR_W must stay consistent (2**REG_ADDR_W == REG_NUM)

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// integer register and operand width
`define XLEN        64

// instruction word, no compressed forms
`define INST_W      32

`define PC_W        64

// ----------------------------------------
// register file
// ----------------------------------------

`define REG_ADDR_W  5
`define REG_NUM     32

`endif

/* hdl/decode_pkg.sv */
// types for the decode stage buses
// enum encodings for opcodes follow the RV64I base opcode map
// the execute stage must decode alu_op_t, src_*_t and res_ext_t the same way

`include "decode_defs.svh"

package decode_pkg;

    // major opcodes kept by this decoder
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_SHAMT} src_b_t;

    // sign: from bit 31, zero: by mem_size (unsigned loads)
    typedef enum logic [1:0] {EXT_NONE, EXT_SIGN, EXT_ZERO} res_ext_t;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_D} mem_size_t;

    // ----------------------------------------
    // stage buses
    // ----------------------------------------

    typedef struct packed {
        logic [`INST_W-1:0] inst;
        logic [`PC_W-1:0]   pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wb_pkt_t;

    // is_load only matters on the execute source
    typedef struct packed {
        logic                   valid;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       data;
    } fwd_pkt_t;

    typedef struct packed {
        alu_op_t                alu_op;
        src_a_t                 src_a;
        src_b_t                 src_b;
        res_ext_t               res_ext;
        logic                   rf_we;
        logic                   mem_we;
        logic                   mem_re;
        mem_size_t              mem_size;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [`XLEN-1:0] rs1_value;
        logic [`XLEN-1:0] rs2_value;
        logic [`PC_W-1:0] pc;
    } decode_pkt_t;

endpackage

/* hdl/inst_decoder.sv */
// combinational RV64I decode, no M, CSR, system or branch/jump forms
// anything not recognised comes out with rf_we, mem_we and mem_re low
// imm is the one immediate execute needs, already extended to XLEN

`timescale 1ns/100ps
`include "decode_defs.svh"

module inst_decoder import decode_pkg::*; (
    input  logic [`INST_W-1:0] inst,
    output ctrl_t              ctrl
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [5:0]       funct6;
    logic             word;
    logic             shift;
    logic             known;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_sh;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // 64-bit shifts borrow funct7[0] as shamt[5]
    assign funct6 = inst[31:26];
    // opcode bit 3 separates the *_32 word forms from the full width ones
    assign word   = opcode[3];
    assign shift  = (funct3[1:0] == 2'b01);

    assign imm_i  = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u  = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    // shift amount is never sign-extended, bit 25 is zero on valid word shifts
    assign imm_sh = {{(`XLEN-6){1'b0}}, inst[25:20]};

    // funct3 picks the operation, alt turns add into sub and srl into sra
    function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = ALU_ADD;
        ctrl.src_a    = SRC_A_RS1;
        ctrl.src_b    = SRC_B_RS2;
        ctrl.res_ext  = EXT_NONE;
        ctrl.mem_size = SIZE_D;
        ctrl.rd       = inst[11:7];
        known         = 1'b0;

        case (opcode)
            OP, OP_32: begin
                // word forms only exist for add, sub and the three shifts
                known = (funct7 == 7'h00 ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) &&
                        (!word || funct3 == 3'b000 || shift);
                ctrl.alu_op  = alu_of(funct3, funct7[5]);
                ctrl.res_ext = word ? EXT_SIGN : EXT_NONE;
            end
            OP_IMM, OP_IMM_32: begin
                if (shift) begin
                    known = word ? (funct7 == 7'h00 || (funct7 == 7'h20 && funct3[2]))
                                 : (funct6 == 6'h00 || (funct6 == 6'h10 && funct3[2]));
                    ctrl.src_b = SRC_B_SHAMT;
                    ctrl.imm   = imm_sh;
                end else begin
                    known      = !word || funct3 == 3'b000;
                    ctrl.src_b = SRC_B_IMM;
                    ctrl.imm   = imm_i;
                end
                // no subi, only the right shift reads bit 30
                ctrl.alu_op  = alu_of(funct3, shift && inst[30]);
                ctrl.res_ext = word ? EXT_SIGN : EXT_NONE;
            end
            LOAD: begin
                known         = funct3 != 3'b111;
                ctrl.src_b    = SRC_B_IMM;
                ctrl.imm      = imm_i;
                ctrl.mem_size = mem_size_t'(funct3[1:0]);
                // ld needs no extension
                ctrl.res_ext  = funct3[2] ? EXT_ZERO :
                                (funct3 == 3'b011) ? EXT_NONE : EXT_SIGN;
            end
            STORE: begin
                known         = !funct3[2];
                ctrl.src_b    = SRC_B_IMM;
                ctrl.imm      = imm_s;
                ctrl.mem_size = mem_size_t'(funct3[1:0]);
            end
            LUI: begin
                known      = 1'b1;
                ctrl.src_a = SRC_A_ZERO;
                ctrl.src_b = SRC_B_IMM;
                ctrl.imm   = imm_u;
            end
            AUIPC: begin
                known      = 1'b1;
                ctrl.src_a = SRC_A_PC;
                ctrl.src_b = SRC_B_IMM;
                ctrl.imm   = imm_u;
            end
            default: known = 1'b0;
        endcase

        ctrl.rf_we  = known && (opcode != STORE);
        ctrl.mem_re = known && (opcode == LOAD);
        ctrl.mem_we = known && (opcode == STORE);
    end

endmodule

/* hdl/reg_file.sv */
// integer register file, two combinational reads and one write per clock
// a read in the same cycle as a write returns the old value,
// the forwarding unit covers that case through the write-back source

`timescale 1ns/100ps
`include "decode_defs.svh"

module reg_file import decode_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  wb_pkt_t                wb
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 must stay zero across any sequence of write-backs
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
        (raddr1 == '0) |-> (rdata1 == '0)
    );

endmodule

/* hdl/operand_forward.sv */
// operand bypass from execute, memory and write-back, in that priority
// a source field of x0 never matches, so x0 always reads as zero
// only execute can raise the load-use stall, a load in memory is
// expected to have its data ready on ms_fwd.data

`timescale 1ns/100ps
`include "decode_defs.svh"

module operand_forward import decode_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`XLEN-1:0]       rf_data1,
    input  logic [`XLEN-1:0]       rf_data2,
    input  fwd_pkt_t               es_fwd,
    input  fwd_pkt_t               ms_fwd,
    input  fwd_pkt_t               ws_fwd,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    output logic                   load_use_stall
);

    logic es_rs1_hit;
    logic es_rs2_hit;

    // one later stage writes the register this field reads
    function automatic logic hit(input fwd_pkt_t src, input logic [`REG_ADDR_W-1:0] rs);
        return src.valid && (src.dest == rs) && (rs != '0);
    endfunction

    // youngest matching result wins, register file otherwise
    function automatic logic [`XLEN-1:0] pick(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rf_data,
        input fwd_pkt_t               es,
        input fwd_pkt_t               ms,
        input fwd_pkt_t               ws
    );
        if (hit(es, rs)) begin
            return es.data;
        end else if (hit(ms, rs)) begin
            return ms.data;
        end else if (hit(ws, rs)) begin
            return ws.data;
        end
        return rf_data;
    endfunction

    assign rs1_value = pick(rs1, rf_data1, es_fwd, ms_fwd, ws_fwd);
    assign rs2_value = pick(rs2, rf_data2, es_fwd, ms_fwd, ws_fwd);

    // ----------------------------------------
    // load-use hazard
    // ----------------------------------------
    // es_fwd.data is not the loaded value yet when execute holds a load
    assign es_rs1_hit     = hit(es_fwd, rs1);
    assign es_rs2_hit     = hit(es_fwd, rs2);
    assign load_use_stall = es_fwd.is_load && (es_rs1_hit || es_rs2_hit);

endmodule

/* hdl/decode_stage.sv */
// decode stage of the five-stage RV64I pipeline
// valid/allowin handshake on both sides, one instruction held at a time
// operand values are combinational from the forward inputs, so ds_pkt only
// stays stable under back-pressure if later stages hold their fwd buses
// flush drops the held instruction and anything fetch offers on that edge

`timescale 1ns/100ps
`include "decode_defs.svh"

module decode_stage import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        fs_valid,
    input  fetch_pkt_t  fs_pkt,
    output logic        ds_allowin,
    output logic        ds_valid_out,
    output decode_pkt_t ds_pkt,
    input  logic        es_allowin,
    input  wb_pkt_t     wb,
    input  fwd_pkt_t    es_fwd,
    input  fwd_pkt_t    ms_fwd,
    input  fwd_pkt_t    ws_fwd
);

    logic                   ds_valid;
    logic                   ds_ready_go;
    logic                   load_use_stall;
    fetch_pkt_t             fs_pkt_r;
    ctrl_t                  ctrl;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rf_data1;
    logic [`XLEN-1:0]       rf_data2;
    logic [`XLEN-1:0]       rs1_value;
    logic [`XLEN-1:0]       rs2_value;

    // ----------------------------------------
    // handshake
    // ----------------------------------------
    assign ds_ready_go  = !load_use_stall;
    assign ds_allowin   = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_valid_out = ds_valid && ds_ready_go && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            fs_pkt_r <= fs_pkt;
        end
    end

    assign rs1 = fs_pkt_r.inst[19:15];
    assign rs2 = fs_pkt_r.inst[24:20];

    inst_decoder u_inst_decoder (
        .inst (fs_pkt_r.inst),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .wb     (wb)
    );

    operand_forward u_operand_forward (
        .rs1            (rs1),
        .rs2            (rs2),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .load_use_stall (load_use_stall)
    );

    assign ds_pkt = '{ctrl: ctrl, rs1_value: rs1_value, rs2_value: rs2_value,
                      pc: fs_pkt_r.pc};

    // a packet handed to execute never reads and writes memory at once
    no_load_and_store: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid_out |-> !(ds_pkt.ctrl.mem_we && ds_pkt.ctrl.mem_re)
    );

endmodule

/* tb/decode_stage_tb.sv */
// testbench for decode_stage, a table of instructions applied one at a time
// register data comes from an xorshift generator with a fixed seed
// forwarding entries make every later stage target the rs1 field only

`timescale 1ns/100ps
`include "decode_defs.svh"

module decode_stage_tb import decode_pkg::*; ();

    localparam int WAIT_LIMIT = 20;

    typedef struct packed {
        logic [`INST_W-1:0] inst;
        logic [`PC_W-1:0]   pc;
        logic [1:0]         fwd_mode;  // 0 none, 1 es+ms+ws, 2 ms+ws
        ctrl_t              ctrl;
    } vector_t;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        fs_valid;
    fetch_pkt_t  fs_pkt;
    logic        ds_allowin;
    logic        ds_valid_out;
    decode_pkt_t ds_pkt;
    logic        es_allowin;
    wb_pkt_t     wb;
    fwd_pkt_t    es_fwd;
    fwd_pkt_t    ms_fwd;
    fwd_pkt_t    ws_fwd;

    vector_t          vectors[$];
    logic [`XLEN-1:0] model [`REG_NUM] = '{default: '0};
    logic [63:0]      rng_state = 64'd98934;
    logic [`XLEN-1:0] es_data;
    logic [`XLEN-1:0] ms_data;
    logic [`XLEN-1:0] ws_data;
    logic [`XLEN-1:0] ld_data;

    decode_stage uut (
        .clk(clk), .reset(reset), .flush(flush),
        .fs_valid(fs_valid), .fs_pkt(fs_pkt), .ds_allowin(ds_allowin),
        .ds_valid_out(ds_valid_out), .ds_pkt(ds_pkt), .es_allowin(es_allowin),
        .wb(wb), .es_fwd(es_fwd), .ms_fwd(ms_fwd), .ws_fwd(ws_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #200us;
        stop_run("simulation ran past its time limit");
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // en is {rf_we, mem_we, mem_re}
    function automatic ctrl_t mk_ctrl(alu_op_t op, src_a_t a, src_b_t b, res_ext_t ext,
                                      logic [2:0] en, mem_size_t sz, logic [4:0] rd,
                                      logic [63:0] imm);
        ctrl_t c;
        c = '{alu_op: op, src_a: a, src_b: b, res_ext: ext, rf_we: en[2], mem_we: en[1],
              mem_re: en[0], mem_size: sz, rd: rd, imm: imm};
        return c;
    endfunction

    task automatic add_vec(input logic [31:0] inst, input logic [1:0] mode, input ctrl_t c);
        logic [63:0] pc;
        pc = 64'h8000_0000 + 64'(4 * vectors.size());
        vectors.push_back('{inst: inst, pc: pc, fwd_mode: mode, ctrl: c});
    endtask

    // expected operands come from the write model and the forwarding priority
    function automatic decode_pkt_t expected_pkt(input vector_t v);
        decode_pkt_t p;
        logic [4:0]  rs1;
        rs1         = v.inst[19:15];
        p.ctrl      = v.ctrl;
        p.pc        = v.pc;
        p.rs1_value = model[rs1];
        p.rs2_value = model[v.inst[24:20]];
        if (rs1 != 5'd0 && v.fwd_mode == 2'd1) begin
            p.rs1_value = es_data;
        end else if (rs1 != 5'd0 && v.fwd_mode == 2'd2) begin
            p.rs1_value = ms_data;
        end
        return p;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_pkt(input decode_pkt_t got, input decode_pkt_t exp, input string what);
        if (got !== exp) begin
            $display("ctrl got %h exp %h", got.ctrl, exp.ctrl);
            $display("rs1 got %h exp %h, rs2 got %h exp %h",
                     got.rs1_value, exp.rs1_value, got.rs2_value, exp.rs2_value);
            stop_run($sformatf("FAIL %0t: %s, decode packet mismatch", $time, what));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic wait_until_allowin();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ds_allowin) begin
            if (cycles == WAIT_LIMIT) stop_run("timeout waiting for ds_allowin");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_until_valid();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ds_valid_out) begin
            if (cycles == WAIT_LIMIT) stop_run("timeout waiting for ds_valid_out");
            cycles++;
            @(negedge clk);
        end
    endtask

    // offer one instruction to the stage and return right after it is taken
    task automatic accept(input vector_t v);
        fwd_pkt_t f;
        @(posedge clk);
        #2;
        f        = '{valid: 1'b1, is_load: 1'b0, dest: v.inst[19:15], data: '0};
        fs_valid = 1'b1;
        fs_pkt   = '{inst: v.inst, pc: v.pc};
        es_fwd   = '0;
        ms_fwd   = '0;
        ws_fwd   = '0;
        if (v.fwd_mode != 2'd0) begin
            ms_fwd      = f;
            ms_fwd.data = ms_data;
            ws_fwd      = f;
            ws_fwd.data = ws_data;
        end
        if (v.fwd_mode == 2'd1) begin
            es_fwd      = f;
            es_fwd.data = es_data;
        end
        wait_until_allowin();
        @(posedge clk);
        #2;
        fs_valid = 1'b0;
    endtask

    task automatic build_vectors();
        // lb lh lw ld lbu lhu lwu, in funct3 order
        res_ext_t  load_ext[7];
        mem_size_t load_size[7];
        load_ext  = '{EXT_SIGN, EXT_SIGN, EXT_SIGN, EXT_NONE, EXT_ZERO, EXT_ZERO, EXT_ZERO};
        load_size = '{SIZE_B, SIZE_H, SIZE_W, SIZE_D, SIZE_B, SIZE_H, SIZE_W};
        add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP), 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd3, '0));
        add_vec(enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd4, OP), 2'd0,
                mk_ctrl(ALU_SUB, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd4, '0));
        add_vec(enc_r(7'h00, 5'd9, 5'd8, 3'b011, 5'd7, OP), 2'd0,
                mk_ctrl(ALU_SLTU, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd7, '0));
        // rs1 is x0, which took a write during setup
        add_vec(enc_r(7'h00, 5'd9, 5'd0, 3'b110, 5'd5, OP), 2'd0,
                mk_ctrl(ALU_OR, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd5, '0));
        add_vec(enc_r(7'h20, 5'd12, 5'd11, 3'b101, 5'd10, OP_32), 2'd0,
                mk_ctrl(ALU_SRA, SRC_A_RS1, SRC_B_RS2, EXT_SIGN, 3'b100, SIZE_D, 5'd10, '0));
        add_vec(enc_i(12'hffb, 5'd17, 3'b100, 5'd16, OP_IMM), 2'd0,
                mk_ctrl(ALU_XOR, SRC_A_RS1, SRC_B_IMM, EXT_NONE, 3'b100, SIZE_D, 5'd16,
                        64'hffff_ffff_ffff_fffb));
        add_vec(enc_i(12'h7ff, 5'd19, 3'b000, 5'd18, OP_IMM_32), 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_IMM, EXT_SIGN, 3'b100, SIZE_D, 5'd18, 64'h7ff));
        // srai by 63 needs the sixth shamt bit
        add_vec(enc_i(12'h43f, 5'd21, 3'b101, 5'd20, OP_IMM), 2'd0,
                mk_ctrl(ALU_SRA, SRC_A_RS1, SRC_B_SHAMT, EXT_NONE, 3'b100, SIZE_D, 5'd20, 64'd63));
        add_vec(enc_i(12'h01f, 5'd23, 3'b001, 5'd22, OP_IMM_32), 2'd0,
                mk_ctrl(ALU_SLL, SRC_A_RS1, SRC_B_SHAMT, EXT_SIGN, 3'b100, SIZE_D, 5'd22, 64'd31));
        for (int f = 0; f < 7; f++) begin
            add_vec(enc_i(12'h800, 5'd13, 3'(f), 5'd14, LOAD), 2'd0,
                    mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_IMM, load_ext[f], 3'b101, load_size[f],
                            5'd14, 64'hffff_ffff_ffff_f800));
        end
        add_vec({7'h7f, 5'd2, 5'd1, 3'b011, 5'h10, STORE}, 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_IMM, EXT_NONE, 3'b010, SIZE_D, 5'h10,
                        64'hffff_ffff_ffff_fff0));
        add_vec({20'h80000, 5'd24, LUI}, 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_ZERO, SRC_B_IMM, EXT_NONE, 3'b100, SIZE_D, 5'd24,
                        64'hffff_ffff_8000_0000));
        add_vec({20'h12345, 5'd25, AUIPC}, 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_PC, SRC_B_IMM, EXT_NONE, 3'b100, SIZE_D, 5'd25,
                        64'h1234_5000));
        add_vec(32'hffff_ffff, 2'd0,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b000, SIZE_D, 5'd31, '0));
        // forwarding priority, then a zero rs1 field that every stage claims
        add_vec(enc_r(7'h00, 5'd28, 5'd27, 3'b000, 5'd26, OP), 2'd1,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd26, '0));
        add_vec(enc_r(7'h00, 5'd28, 5'd27, 3'b000, 5'd26, OP), 2'd2,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd26, '0));
        add_vec(enc_r(7'h00, 5'd28, 5'd0, 3'b000, 5'd29, OP), 2'd1,
                mk_ctrl(ALU_ADD, SRC_A_RS1, SRC_B_RS2, EXT_NONE, 3'b100, SIZE_D, 5'd29, '0));
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        decode_pkt_t exp;
        reset      = 1'b1;
        flush      = 1'b0;
        fs_valid   = 1'b0;
        fs_pkt     = '0;
        es_allowin = 1'b1;
        wb         = '0;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_fwd     = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_bit(ds_allowin, 1'b1, "ds_allowin after reset");
        check_bit(ds_valid_out, 1'b0, "ds_valid_out after reset");

        // fill the register file, x0 included
        for (int i = 0; i < `REG_NUM; i++) begin
            @(posedge clk);
            #2;
            wb = '{we: 1'b1, addr: 5'(i), data: next_rand()};
            if (i != 0) model[i] = wb.data;
        end
        @(posedge clk);
        #2;
        wb      = '0;
        es_data = next_rand();
        ms_data = next_rand();
        ws_data = next_rand();
        ld_data = next_rand();

        build_vectors();
        foreach (vectors[i]) begin
            accept(vectors[i]);
            wait_until_valid();
            check_pkt(ds_pkt, expected_pkt(vectors[i]), $sformatf("vector %0d", i));
        end

        // load in execute writes rs2 of the held add
        accept(vectors[0]);
        es_fwd = '{valid: 1'b1, is_load: 1'b1, dest: 5'd2, data: es_data};
        repeat (3) begin
            @(negedge clk);
            check_bit(ds_valid_out, 1'b0, "ds_valid_out during load-use stall");
            check_bit(ds_allowin, 1'b0, "ds_allowin during load-use stall");
        end
        @(posedge clk);
        #2;
        es_fwd = '0;
        ms_fwd = '{valid: 1'b1, is_load: 1'b1, dest: 5'd2, data: ld_data};
        wait_until_valid();
        exp           = expected_pkt(vectors[0]);
        exp.rs2_value = ld_data;
        check_pkt(ds_pkt, exp, "packet after load-use stall");

        // back-pressure, then flush the held packet
        accept(vectors[1]);
        es_allowin = 1'b0;
        // fetch keeps offering the next instruction, which must stay out
        fs_valid   = 1'b1;
        fs_pkt     = '{inst: vectors[2].inst, pc: vectors[2].pc};
        wait_until_valid();
        repeat (3) begin
            @(negedge clk);
            check_pkt(ds_pkt, expected_pkt(vectors[1]), "packet under back-pressure");
            check_bit(ds_valid_out, 1'b1, "ds_valid_out under back-pressure");
            check_bit(ds_allowin, 1'b0, "ds_allowin under back-pressure");
        end
        @(posedge clk);
        #2;
        flush    = 1'b1;
        fs_valid = 1'b0;
        @(negedge clk);
        check_bit(ds_valid_out, 1'b0, "ds_valid_out during flush");
        @(posedge clk);
        #2;
        flush      = 1'b0;
        es_allowin = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit(ds_valid_out, 1'b0, "ds_valid_out after flush");
            check_bit(ds_allowin, 1'b1, "ds_allowin after flush");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+hdl
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_forward.sv
hdl/decode_stage.sv
tb/decode_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := decode_stage_tb
FILELIST  := decode_stage.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) hdl/decode_defs.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
